//--- fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// word width for instructions and data
`define XLEN 32

// one line buffer entry, filled from burst memory
`define LINE_BITS 256
`define BEAT_BITS 64
`define BEATS_PER_LINE 4

// instruction queue entries
`define IQ_DEPTH 16

// first fetch address after reset
`define RESET_PC 32'haaaaa000

`endif

//--- fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    // one instruction or data word
    typedef logic [`XLEN-1:0] word_t;

    // full line as held by a line buffer
    typedef logic [`LINE_BITS-1:0] line_t;

    // one burst memory beat
    typedef logic [`BEAT_BITS-1:0] beat_t;

    // instruction queue entry, order in the top bits
    typedef struct packed {
        logic [63:0] order;
        word_t       pc;
        word_t       inst;
    } fetch_entry_t;

endpackage

//--- line_buffer.sv
`include "fetch_defs.svh"

module line_buffer
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  load_i,
    input  word_t load_addr_i,
    input  line_t load_line_i,

    input  word_t lookup_addr_i,
    output logic  hit_o,
    output word_t word_o
);

    // byte offset bits within one line
    localparam int OFFSET_BITS = $clog2(`LINE_BITS / 8);

    logic                         valid_q;
    logic [`XLEN-1:OFFSET_BITS]   tag_q;
    line_t                        line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else if (load_i) begin
            valid_q <= 1'b1;
        end
    end

    // tag and line carry no reset, valid bit guards them
    always_ff @(posedge clk) begin
        if (load_i) begin
            tag_q  <= load_addr_i[`XLEN-1:OFFSET_BITS];
            line_q <= load_line_i;
        end
    end

    assign hit_o  = valid_q && (tag_q == lookup_addr_i[`XLEN-1:OFFSET_BITS]);
    assign word_o = line_q[lookup_addr_i[OFFSET_BITS-1:2] * `XLEN +: `XLEN];

endmodule

//--- line_fill_engine.sv
`include "fetch_defs.svh"

module line_fill_engine
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  inst_fill_req_i,
    input  word_t inst_fill_addr_i,
    output logic  inst_fill_done_o,

    input  logic  data_fill_req_i,
    input  word_t data_fill_addr_i,
    output logic  data_fill_done_o,

    output line_t fill_line_o,

    output word_t bmem_addr_o,
    output logic  bmem_read_o,
    input  logic  bmem_ready_i,

    input  word_t bmem_raddr_i,
    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i
);

    localparam int OFFSET_BITS   = $clog2(`LINE_BITS / 8);
    localparam int BEAT_IDX_BITS = $clog2(`BEATS_PER_LINE);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ISSUE,
        FILL_COLLECT
    } fill_state_e;

    fill_state_e              state_q;
    logic [BEAT_IDX_BITS-1:0] beat_cnt_q;
    logic                     done_q;
    logic                     grant_data_q;
    word_t                    addr_q;
    line_t                    line_q;

    logic grant_data;
    logic grant_inst;
    logic beat_accept;
    logic last_beat;

    // no new grant while the done pulse is out, requests still held then
    assign grant_data = (state_q == FILL_IDLE) && !done_q && data_fill_req_i;
    assign grant_inst = (state_q == FILL_IDLE) && !done_q && !data_fill_req_i
                        && inst_fill_req_i;

    // beats for some other burst are ignored
    assign beat_accept = (state_q == FILL_COLLECT) && bmem_rvalid_i
                         && (bmem_raddr_i == addr_q);
    assign last_beat   = (beat_cnt_q == BEAT_IDX_BITS'(`BEATS_PER_LINE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= FILL_IDLE;
            beat_cnt_q   <= '0;
            done_q       <= 1'b0;
            grant_data_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                FILL_IDLE: begin
                    if (grant_data || grant_inst) begin
                        grant_data_q <= grant_data;
                        state_q      <= FILL_ISSUE;
                    end
                end
                FILL_ISSUE: begin
                    // read pulse goes out in this cycle
                    if (bmem_ready_i) begin
                        beat_cnt_q <= '0;
                        state_q    <= FILL_COLLECT;
                    end
                end
                FILL_COLLECT: begin
                    if (beat_accept) begin
                        beat_cnt_q <= beat_cnt_q + 1'b1;
                        if (last_beat) begin
                            done_q  <= 1'b1;
                            state_q <= FILL_IDLE;
                        end
                    end
                end
                default: begin
                    state_q <= FILL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (grant_data) begin
            addr_q <= {data_fill_addr_i[`XLEN-1:OFFSET_BITS], OFFSET_BITS'(0)};
        end else if (grant_inst) begin
            addr_q <= {inst_fill_addr_i[`XLEN-1:OFFSET_BITS], OFFSET_BITS'(0)};
        end
        // lowest beat lands in the lowest bits
        if (beat_accept) begin
            line_q[beat_cnt_q * `BEAT_BITS +: `BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign bmem_addr_o      = addr_q;
    assign bmem_read_o      = (state_q == FILL_ISSUE) && bmem_ready_i;
    assign fill_line_o      = line_q;
    assign data_fill_done_o = done_q && grant_data_q;
    assign inst_fill_done_o = done_q && !grant_data_q;

endmodule

//--- inst_queue.sv
`include "fetch_defs.svh"

module inst_queue
import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush_i,

    input  logic         enq_i,
    input  fetch_entry_t enq_data_i,
    output logic         full_o,

    output logic         deq_valid_o,
    input  logic         deq_ready_i,
    output fetch_entry_t deq_data_o
);

    localparam int PTR_BITS = $clog2(`IQ_DEPTH);

    fetch_entry_t        entries_q [`IQ_DEPTH];
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS:0]   count_q;

    logic do_enq;
    logic do_deq;

    assign full_o      = (count_q == (PTR_BITS + 1)'(`IQ_DEPTH));
    assign deq_valid_o = (count_q != '0);
    assign deq_data_o  = entries_q[rd_ptr_q];

    assign do_enq = enq_i && !full_o;
    assign do_deq = deq_valid_o && deq_ready_i;

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap on their own, depth is a power of two
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_enq, do_deq})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq) begin
            entries_q[wr_ptr_q] <= enq_data_i;
        end
    end

endmodule

//--- fetch_unit.sv
`include "fetch_defs.svh"

module fetch_unit
import fetch_pkg::*;
(
    input  logic         clk,
    input  logic         rst,

    input  logic         redirect_i,
    input  word_t        redirect_pc_i,

    input  logic         queue_full_i,
    output logic         enq_o,
    output fetch_entry_t enq_data_o,

    output logic         inst_fill_req_o,
    output word_t        inst_fill_addr_o,
    input  logic         inst_fill_done_i,
    input  line_t        fill_line_i
);

    word_t       pc_q;
    logic [63:0] order_q;
    logic        fill_pending_q;
    word_t       fill_addr_q;

    logic  lb_hit;
    word_t lb_word;
    logic  start_fill;

    // loads under the address that was requested, even after a redirect
    line_buffer inst_line_buffer (
        .clk           (clk),
        .rst           (rst),
        .load_i        (inst_fill_done_i),
        .load_addr_i   (fill_addr_q),
        .load_line_i   (fill_line_i),
        .lookup_addr_i (pc_q),
        .hit_o         (lb_hit),
        .word_o        (lb_word)
    );

    // redirect wins over any enqueue in the same cycle
    assign enq_o = lb_hit && !queue_full_i && !redirect_i;

    assign enq_data_o.order = order_q;
    assign enq_data_o.pc    = pc_q;
    assign enq_data_o.inst  = lb_word;

    assign start_fill = !lb_hit && !fill_pending_q && !redirect_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q           <= `RESET_PC;
            order_q        <= '0;
            fill_pending_q <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (enq_o) begin
                pc_q <= pc_q + 32'd4;
            end

            // order keeps counting across redirects
            if (enq_o) begin
                order_q <= order_q + 64'd1;
            end

            if (inst_fill_done_i) begin
                fill_pending_q <= 1'b0;
            end else if (start_fill) begin
                fill_pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fill_addr_q <= pc_q;
        end
    end

    assign inst_fill_req_o  = fill_pending_q;
    assign inst_fill_addr_o = fill_addr_q;

endmodule

//--- data_read_unit.sv
module data_read_unit
import fetch_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  dread_valid_i,
    output logic  dread_ready_o,
    input  word_t dread_addr_i,

    output logic  dresp_valid_o,
    output word_t dresp_data_o,

    output logic  data_fill_req_o,
    output word_t data_fill_addr_o,
    input  logic  data_fill_done_i,
    input  line_t fill_line_i
);

    logic  busy_q;
    logic  fill_pending_q;
    word_t addr_q;

    logic  accept;
    logic  lb_hit;
    word_t lb_word;

    line_buffer data_line_buffer (
        .clk           (clk),
        .rst           (rst),
        .load_i        (data_fill_done_i),
        .load_addr_i   (addr_q),
        .load_line_i   (fill_line_i),
        .lookup_addr_i (addr_q),
        .hit_o         (lb_hit),
        .word_o        (lb_word)
    );

    assign dread_ready_o = !busy_q;
    assign accept        = dread_valid_i && dread_ready_o;

    // line only changes at the done edge, so a hit never overlaps a fill
    assign dresp_valid_o = busy_q && lb_hit;
    assign dresp_data_o  = lb_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q         <= 1'b0;
            fill_pending_q <= 1'b0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (dresp_valid_o) begin
                busy_q <= 1'b0;
            end

            if (data_fill_done_i) begin
                fill_pending_q <= 1'b0;
            end else if (busy_q && !lb_hit) begin
                fill_pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= dread_addr_i;
        end
    end

    // latched address stays put until the response
    assign data_fill_req_o  = fill_pending_q;
    assign data_fill_addr_o = addr_q;

endmodule

//--- fetch_top.sv
module fetch_top
import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        redirect_i,
    input  word_t       redirect_pc_i,

    output logic        fetch_valid_o,
    input  logic        fetch_ready_i,
    output logic [63:0] fetch_order_o,
    output word_t       fetch_pc_o,
    output word_t       fetch_inst_o,

    input  logic        dread_valid_i,
    output logic        dread_ready_o,
    input  word_t       dread_addr_i,
    output logic        dresp_valid_o,
    output word_t       dresp_data_o,

    output word_t       bmem_addr_o,
    output logic        bmem_read_o,
    input  logic        bmem_ready_i,
    input  word_t       bmem_raddr_i,
    input  beat_t       bmem_rdata_i,
    input  logic        bmem_rvalid_i
);

    logic         iq_full;
    logic         iq_enq;
    fetch_entry_t iq_enq_data;
    fetch_entry_t iq_head;

    logic  inst_fill_req;
    word_t inst_fill_addr;
    logic  inst_fill_done;
    logic  data_fill_req;
    word_t data_fill_addr;
    logic  data_fill_done;
    line_t fill_line;

    fetch_unit u_fetch (
        .clk              (clk),
        .rst              (rst),
        .redirect_i       (redirect_i),
        .redirect_pc_i    (redirect_pc_i),
        .queue_full_i     (iq_full),
        .enq_o            (iq_enq),
        .enq_data_o       (iq_enq_data),
        .inst_fill_req_o  (inst_fill_req),
        .inst_fill_addr_o (inst_fill_addr),
        .inst_fill_done_i (inst_fill_done),
        .fill_line_i      (fill_line)
    );

    // redirect doubles as the queue flush
    inst_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (redirect_i),
        .enq_i       (iq_enq),
        .enq_data_i  (iq_enq_data),
        .full_o      (iq_full),
        .deq_valid_o (fetch_valid_o),
        .deq_ready_i (fetch_ready_i),
        .deq_data_o  (iq_head)
    );

    assign fetch_order_o = iq_head.order;
    assign fetch_pc_o    = iq_head.pc;
    assign fetch_inst_o  = iq_head.inst;

    data_read_unit u_dread (
        .clk              (clk),
        .rst              (rst),
        .dread_valid_i    (dread_valid_i),
        .dread_ready_o    (dread_ready_o),
        .dread_addr_i     (dread_addr_i),
        .dresp_valid_o    (dresp_valid_o),
        .dresp_data_o     (dresp_data_o),
        .data_fill_req_o  (data_fill_req),
        .data_fill_addr_o (data_fill_addr),
        .data_fill_done_i (data_fill_done),
        .fill_line_i      (fill_line)
    );

    line_fill_engine u_fill (
        .clk              (clk),
        .rst              (rst),
        .inst_fill_req_i  (inst_fill_req),
        .inst_fill_addr_i (inst_fill_addr),
        .inst_fill_done_o (inst_fill_done),
        .data_fill_req_i  (data_fill_req),
        .data_fill_addr_i (data_fill_addr),
        .data_fill_done_o (data_fill_done),
        .fill_line_o      (fill_line),
        .bmem_addr_o      (bmem_addr_o),
        .bmem_read_o      (bmem_read_o),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_raddr_i     (bmem_raddr_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_rvalid_i    (bmem_rvalid_i)
    );

endmodule

//--- fetch_chk.sv
`include "fetch_defs.svh"

module fetch_chk
import fetch_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        redirect_i,
    input logic        fetch_valid_i,
    input logic        fetch_ready_i,
    input logic [63:0] fetch_order_i,
    input word_t       fetch_pc_i,
    input word_t       fetch_inst_i,
    input logic        bmem_read_i,
    input logic        bmem_rvalid_i,
    input logic        dread_valid_i,
    input logic        dread_ready_i,
    input logic        dresp_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_count = 0;

    // beats still owed by the open burst
    logic [2:0] beats_due_q;
    logic       dread_busy_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_due_q  <= '0;
            dread_busy_q <= 1'b0;
        end else begin
            if (bmem_read_i) begin
                beats_due_q <= 3'(`BEATS_PER_LINE);
            end else if (bmem_rvalid_i && beats_due_q != '0) begin
                beats_due_q <= beats_due_q - 1'b1;
            end
            if (dread_valid_i && dread_ready_i) begin
                dread_busy_q <= 1'b1;
            end else if (dresp_valid_i) begin
                dread_busy_q <= 1'b0;
            end
        end
    end

    // a redirect may flush a stalled head
    payload_stable: assert property (@(posedge clk) disable iff (rst)
        fetch_valid_i && !fetch_ready_i && !redirect_i |=>
            fetch_valid_i && $stable({fetch_order_i, fetch_pc_i, fetch_inst_i}))
        else begin
            fail_count++;
            $error("fetch payload changed while stalled");
        end

    one_burst: assert property (@(posedge clk) disable iff (rst)
        bmem_read_i |-> beats_due_q == '0)
        else begin
            fail_count++;
            $error("burst read issued before the previous line returned");
        end

    dread_blocked: assert property (@(posedge clk) disable iff (rst)
        dread_busy_q |-> !dread_ready_i)
        else begin
            fail_count++;
            $error("data read ready while a response is pending");
        end

    dresp_owned: assert property (@(posedge clk) disable iff (rst)
        dresp_valid_i |-> dread_busy_q)
        else begin
            fail_count++;
            $error("data response without an accepted request");
        end

endmodule

bind fetch_top fetch_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .redirect_i    (redirect_i),
    .fetch_valid_i (fetch_valid_o),
    .fetch_ready_i (fetch_ready_i),
    .fetch_order_i (fetch_order_o),
    .fetch_pc_i    (fetch_pc_o),
    .fetch_inst_i  (fetch_inst_o),
    .bmem_read_i   (bmem_read_o),
    .bmem_rvalid_i (bmem_rvalid_i),
    .dread_valid_i (dread_valid_i),
    .dread_ready_i (dread_ready_o),
    .dresp_valid_i (dresp_valid_o)
);

//--- tb_fetch_top.sv
`include "fetch_defs.svh"

module tb_fetch_top
import fetch_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MIN_ENTRIES = 90;
    localparam int STALL_LIMIT = 300;
    localparam int DRESP_LIMIT = 300;
    localparam int RUN_LIMIT   = 20000;

    logic        clk;
    logic        rst;
    logic        redirect_i;
    word_t       redirect_pc_i;
    logic        fetch_valid_o;
    logic        fetch_ready_i;
    logic [63:0] fetch_order_o;
    word_t       fetch_pc_o;
    word_t       fetch_inst_o;
    logic        dread_valid_i;
    logic        dread_ready_o;
    word_t       dread_addr_i;
    logic        dresp_valid_o;
    word_t       dresp_data_o;
    word_t       bmem_addr_o;
    logic        bmem_read_o;
    logic        bmem_ready_i  = 1'b1;
    word_t       bmem_raddr_i  = '0;
    beat_t       bmem_rdata_i  = '0;
    logic        bmem_rvalid_i = 1'b0;

    // memory image and the scripted events from the data file
    word_t mem_words [word_t];
    word_t redir_target [$];
    int    redir_count [$];
    word_t dread_addr_q [$];
    word_t dread_exp_q [$];

    word_t burst_addr = '0;
    int    beats_left = 0;
    int    beat_idx   = 0;

    int fetch_errors = 0;
    int data_errors  = 0;
    int timeouts     = 0;
    int load_errors  = 0;

    fetch_top dut (
        .clk           (clk),
        .rst           (rst),
        .redirect_i    (redirect_i),
        .redirect_pc_i (redirect_pc_i),
        .fetch_valid_o (fetch_valid_o),
        .fetch_ready_i (fetch_ready_i),
        .fetch_order_o (fetch_order_o),
        .fetch_pc_o    (fetch_pc_o),
        .fetch_inst_o  (fetch_inst_o),
        .dread_valid_i (dread_valid_i),
        .dread_ready_o (dread_ready_o),
        .dread_addr_i  (dread_addr_i),
        .dresp_valid_o (dresp_valid_o),
        .dresp_data_o  (dresp_data_o),
        .bmem_addr_o   (bmem_addr_o),
        .bmem_read_o   (bmem_read_o),
        .bmem_ready_i  (bmem_ready_i),
        .bmem_raddr_i  (bmem_raddr_i),
        .bmem_rdata_i  (bmem_rdata_i),
        .bmem_rvalid_i (bmem_rvalid_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    function automatic word_t mem_word(word_t addr);
        if (mem_words.exists(addr)) begin
            return mem_words[addr];
        end
        // words not in the file follow their address
        return addr ^ 32'h9e3779b9;
    endfunction

    task automatic load_input();
        int         fd;
        int         n;
        string      text;
        logic [7:0] kind;
        word_t      a;
        word_t      b;
        fd = $fopen("mem_input.txt", "r");
        if (fd == 0) begin
            $display("could not open mem_input.txt");
            load_errors++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(text, fd);
            if (n > 0 && text.getc(0) != "#") begin
                n = $sscanf(text, "%c %h %h", kind, a, b);
                if (n == 3) begin
                    case (kind)
                        "m": begin
                            mem_words[a] = b;
                        end
                        "r": begin
                            redir_target.push_back(a);
                            redir_count.push_back(int'(b));
                        end
                        "d": begin
                            dread_addr_q.push_back(a);
                            dread_exp_q.push_back(b);
                        end
                        default: begin
                            $display("unknown line kind in mem_input.txt: %s", text);
                            load_errors++;
                        end
                    endcase
                end
            end
        end
        $fclose(fd);
    endtask

    // beat k of a burst carries words 2k and 2k+1 of the line
    always @(negedge clk) begin
        bmem_rvalid_i = 1'b0;
        if (rst) begin
            beats_left = 0;
        end else if (beats_left != 0) begin
            if ($urandom_range(2) != 0) begin
                bmem_rvalid_i = 1'b1;
                bmem_raddr_i  = burst_addr;
                bmem_rdata_i  = {mem_word(burst_addr + word_t'(8 * beat_idx) + 32'd4),
                                 mem_word(burst_addr + word_t'(8 * beat_idx))};
                beat_idx++;
                beats_left--;
            end
        end else if (bmem_read_o) begin
            burst_addr = bmem_addr_o;
            beats_left = `BEATS_PER_LINE;
            beat_idx   = 0;
        end
    end

    task automatic finish_run();
        int assert_fails;
        assert_fails = int'(dut.u_chk.fail_count);
        $display("errors: fetch %0d, data %0d, timeout %0d, load %0d, assertion %0d",
                 fetch_errors, data_errors, timeouts, load_errors, assert_fails);
        if (fetch_errors + data_errors + timeouts + load_errors + assert_fails == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        int          cycle;
        int          stall;
        int          dwait;
        int          seg_count;
        int          total;
        int          redir_idx;
        int          dread_idx;
        bit          dpending;
        bit          after_redirect;
        bit          run_done;
        bit          timed_out;
        logic [63:0] prev_order;
        word_t       exp_pc;
        word_t       exp_dread;
        word_t       cur_daddr;

        void'($urandom(51089));
        rst           = 1'b1;
        redirect_i    = 1'b0;
        redirect_pc_i = '0;
        fetch_ready_i = 1'b0;
        dread_valid_i = 1'b0;
        dread_addr_i  = '0;
        cycle         = 0;
        stall         = 0;
        dwait         = 0;
        seg_count     = 0;
        total         = 0;
        redir_idx     = 0;
        dread_idx     = 0;
        dpending      = 1'b0;
        after_redirect = 1'b0;
        run_done      = 1'b0;
        timed_out     = 1'b0;
        prev_order    = '0;
        exp_pc        = `RESET_PC;
        exp_dread     = '0;
        cur_daddr     = '0;

        load_input();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (!run_done && !timed_out) begin
            // data response first, then maybe a new request
            if (dresp_valid_o) begin
                if (!dpending) begin
                    $display("data response arrived with no read outstanding at %0t", $time);
                    data_errors++;
                end else begin
                    if (dresp_data_o !== exp_dread) begin
                        $display("[ERROR] %0t data read %h: got %h expected %h",
                                 $time, cur_daddr, dresp_data_o, exp_dread);
                        data_errors++;
                    end
                    dpending = 1'b0;
                end
            end
            dread_valid_i = 1'b0;
            if (!dpending && dread_idx < dread_addr_q.size() && dread_ready_o
                && $urandom_range(3) == 0) begin
                dread_valid_i = 1'b1;
                dread_addr_i  = dread_addr_q[dread_idx];
                cur_daddr     = dread_addr_q[dread_idx];
                exp_dread     = dread_exp_q[dread_idx];
                dread_idx++;
                dpending = 1'b1;
                dwait    = 0;
            end
            if (dpending) begin
                dwait++;
                if (dwait > DRESP_LIMIT) begin
                    $display("timeout: no response to data read %h", cur_daddr);
                    timeouts++;
                    timed_out = 1'b1;
                end
            end

            // redirect cycle holds ready low so nothing is taken at the flush
            redirect_i = 1'b0;
            stall++;
            if (redir_idx < redir_target.size() && seg_count == redir_count[redir_idx]) begin
                redirect_i     = 1'b1;
                redirect_pc_i  = redir_target[redir_idx];
                fetch_ready_i  = 1'b0;
                exp_pc         = redir_target[redir_idx];
                redir_idx++;
                seg_count      = 0;
                after_redirect = 1'b1;
                stall          = 0;
            end else begin
                // ready is mostly low so the queue fills and the pc stalls
                fetch_ready_i = ($urandom_range(3) == 0);
                if (fetch_valid_o && fetch_ready_i) begin
                    if (fetch_pc_o !== exp_pc) begin
                        $display("[ERROR] %0t fetch pc: got %h expected %h",
                                 $time, fetch_pc_o, exp_pc);
                        fetch_errors++;
                    end
                    if (fetch_inst_o !== mem_word(exp_pc)) begin
                        $display("[ERROR] %0t fetch inst at %h: got %h expected %h",
                                 $time, exp_pc, fetch_inst_o, mem_word(exp_pc));
                        fetch_errors++;
                    end
                    if (total == 0 && fetch_order_o !== 64'd0) begin
                        $display("[ERROR] %0t first order: got %0d expected 0",
                                 $time, fetch_order_o);
                        fetch_errors++;
                    end else if (total > 0 && after_redirect && fetch_order_o <= prev_order) begin
                        $display("[ERROR] %0t order after redirect: got %0d, last was %0d",
                                 $time, fetch_order_o, prev_order);
                        fetch_errors++;
                    end else if (total > 0 && !after_redirect
                                 && fetch_order_o !== prev_order + 64'd1) begin
                        $display("[ERROR] %0t order: got %0d expected %0d",
                                 $time, fetch_order_o, prev_order + 64'd1);
                        fetch_errors++;
                    end
                    prev_order     = fetch_order_o;
                    exp_pc         = exp_pc + 32'd4;
                    seg_count++;
                    total++;
                    after_redirect = 1'b0;
                    stall          = 0;
                end
            end
            if (stall > STALL_LIMIT) begin
                $display("timeout: no fetch entry delivered for %0d cycles", stall);
                timeouts++;
                timed_out = 1'b1;
            end

            cycle++;
            if (cycle > RUN_LIMIT) begin
                $display("timeout: run did not finish within %0d cycles", RUN_LIMIT);
                timeouts++;
                timed_out = 1'b1;
            end
            run_done = (redir_idx == redir_target.size()) && (dread_idx == dread_addr_q.size())
                       && !dpending && total >= MIN_ENTRIES;
            @(negedge clk);
        end

        redirect_i    = 1'b0;
        fetch_ready_i = 1'b0;
        dread_valid_i = 1'b0;
        repeat (2) @(negedge clk);
        finish_run();
    end

endmodule

//--- mem_input.txt
# all fields hex. m addr word: memory word. r target count: redirect after count entries
# since reset or the previous redirect. d addr word: data read and its expected word
m aaaaa000 00000013
m aaaaa004 00100093
m aaaaa008 00200113
m aaaaa00c 00308193
m aaaaa010 00410213
m aaaaa020 0ff00293
m aaaab000 00a00313
m aaaab004 00b00393
m aaaaa100 12345678
m aaaac020 87654321
m aaaac03c 0c0ffee0
m 10000000 11112222
m 10000004 33334444
m 1000001c deadbeef
m 10000020 cafef00d
m 20000040 0badc0de
r aaaab000 14
r aaaaa100 0c
r aaaac020 09
d 10000004 33334444
d 1000001c deadbeef
d 10000000 11112222
d 10000020 cafef00d
d 20000040 0badc0de
d aaaaa004 00100093

//--- compile.f
+incdir+.
fetch_pkg.sv
line_buffer.sv
line_fill_engine.sv
inst_queue.sv
fetch_unit.sv
data_read_unit.sv
fetch_top.sv
fetch_chk.sv
tb_fetch_top.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -j 0 --top-module tb_fetch_top -f compile.f -o tb_sim
./obj_dir/tb_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
if grep -q "^Test completed successfully$" sim.log; then
    echo "simulation passed"
else
    echo "simulation did not pass"
    exit 1
fi
